//--- design/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

	// Register and memory word width
	localparam int XLEN = 64;

	// Byte lanes per doubleword
	localparam int STRB_W = XLEN / 8;

	// Byte offset bits inside one doubleword
	localparam int OFFS_W = 3;

	// Row index width of one bank
	localparam int BANK_AW = 10;

	// Doublewords per bank, two banks give 16 KiB
	localparam int BANK_DEPTH = 1 << BANK_AW;

	// Destination tag, five register bits plus rename bit
	localparam int RD_W = 6;

	// Load access widths
	typedef enum logic [1:0] {
		LOAD_B,
		LOAD_H,
		LOAD_W,
		LOAD_D
	} load_op_e;

	// Store access widths
	typedef enum logic [1:0] {
		STORE_B,
		STORE_H,
		STORE_W,
		STORE_D
	} store_op_e;

endpackage

`default_nettype wire

//--- design/dtcm_bank.sv
`timescale 1ns/1ps
`default_nettype none

module dtcm_bank (
	input  wire logic                       CLK,
	input  wire logic [lsu_pkg::BANK_AW-1:0] index,
	input  wire logic [lsu_pkg::XLEN-1:0]    wdata,
	input  wire logic                       wen,
	input  wire logic [lsu_pkg::STRB_W-1:0]  wmask,
	output logic      [lsu_pkg::XLEN-1:0]    rdata
);

	import lsu_pkg::*;

	// Doubleword storage array
	logic [XLEN-1:0] mem [0:BANK_DEPTH-1];

	// Byte-masked write at the accepting edge
	always_ff @(posedge CLK) begin
		if (wen) begin
			for (int b = 0; b < STRB_W; b++) begin
				// Only lanes selected by the store mask
				if (wmask[b]) begin
					mem[index][b*8 +: 8] <= wdata[b*8 +: 8];
				end
			end
		end
	end

	// Registered read, one cycle latency
	// Same-edge write returns old word; only stores do that and they drop the data
	always_ff @(posedge CLK) begin
		rdata <= mem[index];
	end

endmodule

`default_nettype wire

//--- design/store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align (
	input  wire lsu_pkg::store_op_e          store_op,
	input  wire logic [63:0]                 store_addr,
	input  wire logic [lsu_pkg::XLEN-1:0]    store_data,
	output logic      [lsu_pkg::STRB_W-1:0]  wmask_even,
	output logic      [lsu_pkg::STRB_W-1:0]  wmask_odd,
	output logic      [lsu_pkg::XLEN-1:0]    wdata_even,
	output logic      [lsu_pkg::XLEN-1:0]    wdata_odd
);

	import lsu_pkg::*;

	// Byte offset inside the first doubleword
	logic [OFFS_W-1:0] offset;

	// Set when the first doubleword lives in the odd bank
	logic odd_first;

	// Unshifted byte mask for the access width
	logic [2*STRB_W-1:0] base_mask;

	// 16-byte window, low half is the addressed doubleword
	logic [2*STRB_W-1:0] win_mask;
	logic [2*XLEN-1:0]   win_data;

	assign offset    = store_addr[OFFS_W-1:0];
	assign odd_first = store_addr[OFFS_W];

	// Width to contiguous byte lanes
	always_comb begin
		base_mask = '0;
		case (store_op)
			STORE_B: base_mask[0]   = 1'b1;
			STORE_H: base_mask[1:0] = 2'b11;
			STORE_W: base_mask[3:0] = 4'hf;
			STORE_D: base_mask[7:0] = 8'hff;
		endcase
	end

	// Slide mask and data up to the byte offset
	assign win_mask = base_mask << offset;
	assign win_data = {{XLEN{1'b0}}, store_data} << {offset, 3'b000};

	// Halves swap when the access starts in the odd bank
	always_comb begin
		if (odd_first) begin
			wmask_odd  = win_mask[STRB_W-1:0];
			wdata_odd  = win_data[XLEN-1:0];
			wmask_even = win_mask[2*STRB_W-1:STRB_W];
			wdata_even = win_data[2*XLEN-1:XLEN];
		end else begin
			wmask_even = win_mask[STRB_W-1:0];
			wdata_even = win_data[XLEN-1:0];
			wmask_odd  = win_mask[2*STRB_W-1:STRB_W];
			wdata_odd  = win_data[2*XLEN-1:XLEN];
		end
	end

endmodule

`default_nettype wire

//--- design/lsu_issue.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_issue (
	input  wire logic                        CLK,
	input  wire logic                        reset,
	input  wire logic                        load_valid,
	input  wire logic                        load_unsigned,
	input  wire lsu_pkg::load_op_e           load_op,
	input  wire logic [63:0]                 load_addr,
	input  wire logic [lsu_pkg::RD_W-1:0]    load_rd,
	input  wire logic                        store_valid,
	input  wire logic [63:0]                 store_addr,
	output logic                             load_ready,
	output logic                             store_ready,
	output logic      [lsu_pkg::BANK_AW-1:0] index_even,
	output logic      [lsu_pkg::BANK_AW-1:0] index_odd,
	output logic                             bank_wen,
	output logic                             wb_valid,
	output logic      [lsu_pkg::RD_W-1:0]    wb_rd,
	output logic                             wb_is_load,
	output logic                             wb_unsigned,
	output logic                             wb_odd_first,
	output lsu_pkg::load_op_e                wb_op,
	output logic      [lsu_pkg::OFFS_W-1:0]  wb_offset
);

	import lsu_pkg::*;

	// Handshake results this cycle
	logic load_fire;
	logic store_fire;
	logic op_fire;

	// Address of the operation going to memory
	logic [63:0] act_addr;

	// Row of the first doubleword, halved doubleword index
	logic [BANK_AW-1:0] row;

	// Memory never stalls, only reset holds loads off
	assign load_ready = ~reset;

	// Any pending load blocks the store
	assign store_ready = ~reset & ~load_valid;

	assign load_fire  = load_valid & load_ready;
	assign store_fire = store_valid & store_ready;
	assign op_fire    = load_fire | store_fire;

	// Load address wins, store address otherwise
	assign act_addr = load_fire ? load_addr : store_addr;

	assign row = act_addr[OFFS_W+1 +: BANK_AW];

	// Odd-first access spills into the next even row
	assign index_odd  = row;
	assign index_even = act_addr[OFFS_W] ? row + BANK_AW'(1) : row;

	// Banks write only for an accepted store
	assign bank_wen = store_fire;

	// Write-back valid and load flag
	always_ff @(posedge CLK) begin
		if (reset) begin
			wb_valid   <= 1'b0;
			wb_is_load <= 1'b0;
		end else begin
			wb_valid   <= op_fire;
			wb_is_load <= load_fire;
		end
	end

	// Control fields for the aligner, lined up with bank read data
	always_ff @(posedge CLK) begin
		if (op_fire) begin
			// Stores report tag zero
			wb_rd        <= load_fire ? load_rd : '0;
			wb_op        <= load_op;
			wb_unsigned  <= load_unsigned;
			wb_offset    <= act_addr[OFFS_W-1:0];
			wb_odd_first <= act_addr[OFFS_W];
		end
	end

endmodule

`default_nettype wire

//--- design/load_align.sv
`timescale 1ns/1ps
`default_nettype none

module load_align (
	input  wire logic [lsu_pkg::XLEN-1:0]   rdata_even,
	input  wire logic [lsu_pkg::XLEN-1:0]   rdata_odd,
	input  wire logic                       wb_is_load,
	input  wire logic                       wb_unsigned,
	input  wire logic                       wb_odd_first,
	input  wire lsu_pkg::load_op_e          wb_op,
	input  wire logic [lsu_pkg::OFFS_W-1:0] wb_offset,
	output logic      [lsu_pkg::XLEN-1:0]   wb_data
);

	import lsu_pkg::*;

	// Both bank words in address order
	logic [2*XLEN-1:0] window;

	// Window moved down to the addressed byte
	logic [2*XLEN-1:0] shifted;

	// Addressed bytes at bit zero
	logic [XLEN-1:0] picked;

	// Extended result before the load gate
	logic [XLEN-1:0] ext;

	// Lower address doubleword goes low
	assign window = wb_odd_first ? {rdata_even, rdata_odd} : {rdata_odd, rdata_even};

	assign shifted = window >> {wb_offset, 3'b000};
	assign picked  = shifted[XLEN-1:0];

	// Width select and sign or zero fill
	always_comb begin
		ext = picked;
		case (wb_op)
			LOAD_B: begin
				ext = wb_unsigned ? {{(XLEN-8){1'b0}}, picked[7:0]}
				                  : {{(XLEN-8){picked[7]}}, picked[7:0]};
			end
			LOAD_H: begin
				ext = wb_unsigned ? {{(XLEN-16){1'b0}}, picked[15:0]}
				                  : {{(XLEN-16){picked[15]}}, picked[15:0]};
			end
			LOAD_W: begin
				ext = wb_unsigned ? {{(XLEN-32){1'b0}}, picked[31:0]}
				                  : {{(XLEN-32){picked[31]}}, picked[31:0]};
			end
			// Full doubleword, nothing to extend
			LOAD_D: ext = picked;
		endcase
	end

	// Stores complete with zero data
	assign wb_data = wb_is_load ? ext : '0;

endmodule

`default_nettype wire

//--- design/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu (
	input  wire logic                     CLK,
	input  wire logic                     reset,
	input  wire logic                     load_valid,
	output logic                          load_ready,
	input  wire lsu_pkg::load_op_e        load_op,
	input  wire logic                     load_unsigned,
	input  wire logic [63:0]              load_addr,
	input  wire logic [lsu_pkg::RD_W-1:0] load_rd,
	input  wire logic                     store_valid,
	output logic                          store_ready,
	input  wire lsu_pkg::store_op_e       store_op,
	input  wire logic [63:0]              store_addr,
	input  wire logic [lsu_pkg::XLEN-1:0] store_data,
	output logic                          wb_valid,
	output logic      [lsu_pkg::RD_W-1:0] wb_rd,
	output logic      [lsu_pkg::XLEN-1:0] wb_data
);

	import lsu_pkg::*;

	// Bank rows and write enable
	logic [BANK_AW-1:0] index_even;
	logic [BANK_AW-1:0] index_odd;
	logic               bank_wen;

	// Per-bank store lanes
	logic [STRB_W-1:0] wmask_even;
	logic [STRB_W-1:0] wmask_odd;
	logic [XLEN-1:0]   wdata_even;
	logic [XLEN-1:0]   wdata_odd;

	// Registered bank reads
	logic [XLEN-1:0] rdata_even;
	logic [XLEN-1:0] rdata_odd;

	// Write-back stage control
	logic              wb_is_load;
	logic              wb_unsigned;
	logic              wb_odd_first;
	load_op_e          wb_op;
	logic [OFFS_W-1:0] wb_offset;

	lsu_issue u_issue (
		.CLK(CLK), .reset(reset),
		.load_valid(load_valid), .load_unsigned(load_unsigned),
		.load_op(load_op), .load_addr(load_addr), .load_rd(load_rd),
		.store_valid(store_valid), .store_addr(store_addr),
		.load_ready(load_ready), .store_ready(store_ready),
		.index_even(index_even), .index_odd(index_odd), .bank_wen(bank_wen),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_is_load(wb_is_load),
		.wb_unsigned(wb_unsigned), .wb_odd_first(wb_odd_first),
		.wb_op(wb_op), .wb_offset(wb_offset)
	);

	// Store lanes split across both banks
	store_align u_store_align (
		.store_op(store_op), .store_addr(store_addr), .store_data(store_data),
		.wmask_even(wmask_even), .wmask_odd(wmask_odd),
		.wdata_even(wdata_even), .wdata_odd(wdata_odd)
	);

	// Doublewords with address bit 3 clear
	dtcm_bank bank_even (
		.CLK(CLK), .index(index_even), .wdata(wdata_even),
		.wen(bank_wen), .wmask(wmask_even), .rdata(rdata_even)
	);

	// Doublewords with address bit 3 set
	dtcm_bank bank_odd (
		.CLK(CLK), .index(index_odd), .wdata(wdata_odd),
		.wen(bank_wen), .wmask(wmask_odd), .rdata(rdata_odd)
	);

	load_align u_load_align (
		.rdata_even(rdata_even), .rdata_odd(rdata_odd),
		.wb_is_load(wb_is_load), .wb_unsigned(wb_unsigned),
		.wb_odd_first(wb_odd_first), .wb_op(wb_op),
		.wb_offset(wb_offset), .wb_data(wb_data)
	);

endmodule

`default_nettype wire

//--- testbench/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

	import lsu_pkg::*;

	localparam int MEM_BYTES = 2 * BANK_DEPTH * STRB_W;
	localparam int SEED = 62;
	localparam int RESET_CYCLES = 5;
	// Preloaded low region and top doubleword row
	localparam int INIT_LOW = 512;
	localparam int TOP_BASE = MEM_BYTES - 64;
	localparam logic [63:0] TOP_DW = 64'(MEM_BYTES - 8);
	localparam int RAND_WINDOW = 256;
	localparam logic [63:0] SIGN_BYTES = 64'h8080_8080_8080_8080;
	// Operations per test phase
	localparam int INIT_OPS = INIT_LOW / 8 + 8;
	localparam int ALIGN_OPS = 4 * 2 * 9;
	localparam int MISALIGN_OPS = 2 * 7 * 4 * 5 + 7 * 4;
	localparam int PRIO_OPS = 4 * 5;
	localparam int RAND_OPS = 400;
	localparam int OP_COUNT = INIT_OPS + ALIGN_OPS + MISALIGN_OPS + PRIO_OPS + RAND_OPS;
	localparam int WATCHDOG_CYCLES = OP_COUNT * 4 + 100;

	logic            CLK;
	logic            reset;
	logic            load_valid;
	logic            load_ready;
	load_op_e        load_op;
	logic            load_unsigned;
	logic [63:0]     load_addr;
	logic [RD_W-1:0] load_rd;
	logic            store_valid;
	logic            store_ready;
	store_op_e       store_op;
	logic [63:0]     store_addr;
	logic [XLEN-1:0] store_data;
	logic            wb_valid;
	logic [RD_W-1:0] wb_rd;
	logic [XLEN-1:0] wb_data;

	// Byte-wide reference memory
	logic [7:0] model [0:MEM_BYTES-1];

	// Expected write-backs in acceptance order
	logic [RD_W-1:0] exp_rd_q[$];
	logic [XLEN-1:0] exp_data_q[$];

	int errors = 0;
	int checks = 0;

	lsu DUT (
		.CLK(CLK), .reset(reset),
		.load_valid(load_valid), .load_ready(load_ready), .load_op(load_op),
		.load_unsigned(load_unsigned), .load_addr(load_addr), .load_rd(load_rd),
		.store_valid(store_valid), .store_ready(store_ready), .store_op(store_op),
		.store_addr(store_addr), .store_data(store_data),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	initial CLK = 1'b0;
	always #10 CLK = ~CLK;

	task automatic check_value(input string name, input logic [63:0] actual,
	                           input logic [63:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// Width code 0..3 means 1, 2, 4 or 8 bytes, address wraps at memory size
	function automatic logic [63:0] expected_load(input logic [63:0] addr, input int width,
	                                              input bit uns);
		int nbytes;
		logic [63:0] raw;
		nbytes = 1 << width;
		raw = '0;
		for (int i = 0; i < nbytes; i++) begin
			raw[i*8 +: 8] = model[int'((addr + 64'(i)) % MEM_BYTES)];
		end
		// Sign fill above the loaded bytes
		if (!uns && nbytes < 8 && raw[nbytes*8-1] === 1'b1) begin
			raw = raw | ({64{1'b1}} << (nbytes * 8));
		end
		return raw;
	endfunction

	task automatic store_model(input logic [63:0] addr, input int width,
	                           input logic [63:0] data);
		for (int i = 0; i < (1 << width); i++) begin
			model[int'((addr + 64'(i)) % MEM_BYTES)] = data[i*8 +: 8];
		end
	endtask

	task automatic set_load(input logic [63:0] addr, input int width, input bit uns,
	                        input logic [RD_W-1:0] rd);
		load_addr     = addr;
		load_op       = load_op_e'(width);
		load_unsigned = uns;
		load_rd       = rd;
		load_valid    = 1'b1;
	endtask

	task automatic set_store(input logic [63:0] addr, input int width,
	                         input logic [63:0] data);
		store_addr  = addr;
		store_op    = store_op_e'(width);
		store_data  = data;
		store_valid = 1'b1;
	endtask

	// One clock, inputs already set at the falling edge
	task automatic step(output bit ld_acc, output bit st_acc);
		@(posedge CLK);
		ld_acc = load_valid && load_ready;
		st_acc = store_valid && store_ready;
		if (ld_acc && st_acc) begin
			errors++;
			$display("ERROR at %0t: a load and a store were accepted in the same cycle", $time);
		end
		if (ld_acc) begin
			exp_rd_q.push_back(load_rd);
			exp_data_q.push_back(expected_load(load_addr, int'(load_op), load_unsigned));
		end else if (st_acc) begin
			store_model(store_addr, int'(store_op), store_data);
			exp_rd_q.push_back('0);
			exp_data_q.push_back('0);
		end
		@(negedge CLK);
	endtask

	task automatic do_load(input logic [63:0] addr, input int width, input bit uns);
		bit ld_acc;
		bit st_acc;
		set_load(addr, width, uns, RD_W'($urandom));
		store_valid = 1'b0;
		step(ld_acc, st_acc);
		if (!ld_acc) begin
			errors++;
			$display("ERROR at %0t: load was not accepted although reset is low", $time);
		end
		load_valid = 1'b0;
	endtask

	task automatic do_store(input logic [63:0] addr, input int width, input logic [63:0] data);
		bit ld_acc;
		bit st_acc;
		int tries;
		set_store(addr, width, data);
		load_valid = 1'b0;
		tries = 0;
		do begin
			step(ld_acc, st_acc);
			tries++;
		end while (!st_acc && tries < 4);
		if (!st_acc) begin
			errors++;
			$display("ERROR at %0t: store was not accepted with the load port idle", $time);
		end
		store_valid = 1'b0;
	endtask

	// Compare write-back mid-cycle, where outputs are settled
	always @(negedge CLK) begin
		if (wb_valid === 1'b1) begin
			if (exp_rd_q.size() == 0) begin
				errors++;
				$display("ERROR at %0t: write-back seen with no operation outstanding", $time);
			end else begin
				check_value("wb_rd", wb_rd, exp_rd_q.pop_front());
				check_value("wb_data", wb_data, exp_data_q.pop_front());
			end
		end else if (exp_rd_q.size() != 0) begin
			errors++;
			$display("ERROR at %0t: write-back missing in the cycle after acceptance", $time);
			void'(exp_rd_q.pop_front());
			void'(exp_data_q.pop_front());
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		errors++;
		$display("ERROR: watchdog expired after %0d cycles, stimulus did not complete",
		         WATCHDOG_CYCLES);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		bit ld_acc;
		bit st_acc;
		bit pending;
		bit last_store;
		int done;
		int width;
		logic [63:0] addr;
		logic [63:0] base;
		logic [63:0] data;
		reset = 1'b1;
		load_valid = 1'b0;
		load_op = LOAD_B;
		load_unsigned = 1'b0;
		load_addr = '0;
		load_rd = '0;
		store_valid = 1'b0;
		store_op = STORE_B;
		store_addr = '0;
		store_data = '0;
		void'($urandom(SEED));

		// Reset holds both ports off and write-back idle
		repeat (RESET_CYCLES) begin
			@(negedge CLK);
			check_value("wb_valid", wb_valid, 0);
			check_value("load_ready", load_ready, 0);
			check_value("store_ready", store_ready, 0);
		end
		reset = 1'b0;
		@(negedge CLK);
		check_value("wb_valid", wb_valid, 0);
		check_value("load_ready", load_ready, 1);
		check_value("store_ready", store_ready, 1);

		// Preload every byte that later loads touch
		for (int a = 0; a < INIT_LOW; a += 8) begin
			do_store(64'(a), 3, {$urandom, $urandom});
		end
		for (int a = TOP_BASE; a < MEM_BYTES; a += 8) begin
			do_store(64'(a), 3, {$urandom, $urandom});
		end

		// Aligned stores, then every load width both signed and unsigned
		for (int w = 0; w < 4; w++) begin
			for (int rep = 0; rep < 2; rep++) begin
				addr = 64'(64 + w * 16 + rep * 8);
				data = {$urandom, $urandom};
				data = rep ? data & ~SIGN_BYTES : data | SIGN_BYTES;
				do_store(addr, w, data);
				for (int lw = 0; lw < 4; lw++) begin
					do_load(addr, lw, 1'b0);
					do_load(addr, lw, 1'b1);
				end
			end
		end

		// Offsets 1..7 in both banks, neighbours read back as doublewords
		for (int b3 = 0; b3 < 2; b3++) begin
			for (int off = 1; off < 8; off++) begin
				for (int w = 0; w < 4; w++) begin
					base = 64'(256 + b3 * 8);
					addr = base + 64'(off);
					data = {$urandom, $urandom};
					data = ((off + w) % 2) ? data | SIGN_BYTES : data & ~SIGN_BYTES;
					do_store(addr, w, data);
					do_load(base, 3, 1'b1);
					do_load(base + 64'd8, 3, 1'b1);
					do_load(addr, w, 1'b0);
					do_load(addr, w, 1'b1);
				end
			end
		end

		// Last odd row wraps into even row 0
		for (int off = 1; off < 8; off++) begin
			do_store(TOP_DW + 64'(off), 3, {$urandom, $urandom} | SIGN_BYTES);
			do_load(TOP_DW, 3, 1'b1);
			do_load(64'd0, 3, 1'b1);
			do_load(TOP_DW + 64'(off), 3, 1'b0);
		end

		// Store held off by loads to its own address
		for (int i = 0; i < 4; i++) begin
			addr = 64'(128 + i * 8 + 3);
			set_store(addr, 2, {$urandom, $urandom} | SIGN_BYTES);
			repeat (3) begin
				set_load(addr, 2, 1'b0, RD_W'($urandom));
				step(ld_acc, st_acc);
				check_value("store_ready", store_ready, 0);
			end
			load_valid = 1'b0;
			step(ld_acc, st_acc);
			if (!st_acc) begin
				errors++;
				$display("ERROR at %0t: held store not accepted once loads paused", $time);
			end
			store_valid = 1'b0;
			do_load(addr, 2, 1'b0);
		end

		// Random stream, stores held until accepted
		done = 0;
		pending = 1'b0;
		last_store = 1'b0;
		while (done < RAND_OPS) begin
			if (!pending && ($urandom % 10) < 6) begin
				set_store(64'($urandom % RAND_WINDOW), $urandom % 4, {$urandom, $urandom});
				pending = 1'b1;
			end
			if (last_store && ($urandom % 2)) begin
				// Read back the bytes just written
				set_load(addr, width, $urandom % 2, RD_W'($urandom));
			end else if (($urandom % 10) < 6) begin
				set_load(64'($urandom % RAND_WINDOW), $urandom % 4, $urandom % 2,
				         RD_W'($urandom));
			end else begin
				load_valid = 1'b0;
			end
			step(ld_acc, st_acc);
			last_store = st_acc;
			if (st_acc) begin
				addr = store_addr;
				width = int'(store_op);
				pending = 1'b0;
				store_valid = 1'b0;
			end
			done += int'(ld_acc) + int'(st_acc);
		end
		load_valid = 1'b0;
		store_valid = 1'b0;

		// Drain the last write-back
		repeat (3) @(negedge CLK);
		if (exp_rd_q.size() != 0) begin
			errors++;
			$display("ERROR: %0d accepted operations never wrote back", exp_rd_q.size());
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- lsu.f
design/lsu_pkg.sv
design/dtcm_bank.sv
design/store_align.sv
design/lsu_issue.sv
design/load_align.sv
design/lsu.sv
testbench/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - target: any(rtl, test)
    files:
      - design/lsu_pkg.sv
      - design/dtcm_bank.sv
      - design/store_align.sv
      - design/lsu_issue.sv
      - design/load_align.sv
      - design/lsu.sv
  - target: test
    files:
      - testbench/lsu_tb.sv
